// ==== mul8_apb.f ====
hw/mul_pkg.sv
hw/ks_adder.sv
hw/dadda_reduce.sv
hw/final_add.sv
hw/mul_apb_regs.sv
hw/mul8_apb.sv
dv/tb_clk_gen.sv
dv/mul8_apb_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root
# the exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
    --top-module mul8_apb_tb \
    -f mul8_apb.f \
    -o sim_mul8_apb &&
./obj_dir/sim_mul8_apb || { echo "run.sh: build or simulation returned an error"; exit 1; }

// ==== dv/mul8_apb_tb.sv ====
module mul8_apb_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import mul_pkg::*;

    localparam int RST_CYC = 8;
    localparam int N_FIXED = 8;
    localparam int N_RAND  = 16;
    localparam int N_ROWS  = N_FIXED + N_RAND;
    localparam int SEED    = 70746;
    // reset, about 10 cycles per table row, directed tests and margin
    localparam int TIMEOUT_CYC = RST_CYC + N_ROWS * 10 + 152;
    localparam logic [APB_AW-1:0] ADDR_UNMAPPED = 8'h08;

    typedef struct {
        logic [7:0]  a;
        logic [7:0]  b;
        logic [15:0] prod;
        logic        err;
        string       name;
    } row_t;

    logic     clk;
    logic     rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     last_pready;
    int       cycles = 0;
    row_t     tbl [N_ROWS];

    tb_clk_gen #(.PERIOD(20), .RST_CYC(RST_CYC)) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mul8_apb DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYC) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("Testbench failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // one full setup + access transfer, response sampled mid access phase
    task automatic apb_transfer(input logic write, input logic [APB_AW-1:0] addr,
                                input logic [APB_DW-1:0] wdata,
                                output logic [APB_DW-1:0] rdata, output logic err);
        apb_req_t word;
        word         = '0;
        word.psel    = 1'b1;
        word.pwrite  = write;
        word.paddr   = addr;
        word.pwdata  = wdata;
        @(posedge clk);
        apb_req <= word;
        @(posedge clk);
        word.penable = 1'b1;
        apb_req <= word;
        @(negedge clk);
        last_pready = apb_rsp.pready;  // first access cycle
        while (apb_rsp.pready !== 1'b1) begin
            @(negedge clk);
        end
        rdata       = apb_rsp.prdata;
        err         = apb_rsp.pslverr;
        @(posedge clk);
        apb_req <= '0;  // completes on this edge
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                             output logic err);
        logic [APB_DW-1:0] unused_rd;
        apb_transfer(1'b1, addr, data, unused_rd, err);
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                            output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    function automatic logic [31:0] product_word(input logic [15:0] prod, input logic done);
        return {15'b0, done, prod};
    endfunction

    function automatic logic [31:0] operand_word(input logic [7:0] a, input logic [7:0] b);
        return {16'b0, b, a};
    endfunction

    task automatic set_row(input int idx, input logic [7:0] a, input logic [7:0] b,
                           input logic [15:0] prod, input string name);
        tbl[idx].a    = a;
        tbl[idx].b    = b;
        tbl[idx].prod = prod;
        tbl[idx].err  = 1'b0;
        tbl[idx].name = name;
    endtask

    task automatic fill_table;
        int unsigned r;
        set_row(0, 8'd0,   8'd200, 16'h0000, "zero_a");
        set_row(1, 8'd77,  8'd0,   16'h0000, "zero_b");
        set_row(2, 8'd1,   8'd173, 16'h00ad, "one_a");
        set_row(3, 8'd214, 8'd1,   16'h00d6, "one_b");
        set_row(4, 8'd255, 8'd255, 16'hfe01, "max_max");
        set_row(5, 8'd128, 8'd128, 16'h4000, "pow2_hi");
        set_row(6, 8'd2,   8'd64,  16'h0080, "pow2_mix");
        set_row(7, 8'd16,  8'd16,  16'h0100, "pow2_lo");
        for (int k = N_FIXED; k < N_ROWS; k++) begin
            r = $urandom();
            set_row(k, r[7:0], r[15:8], {8'b0, r[7:0]} * {8'b0, r[15:8]},
                    $sformatf("rand_%0d", k - N_FIXED));
        end
    endtask

    initial begin
        logic [31:0]       rd;
        logic              err;
        logic [7:0]        a_last;
        logic [7:0]        b_last;
        logic [15:0]       p_last;
        logic [7:0]        a2;
        logic [7:0]        b2;

        apb_req  <= '0;
        void'($urandom(SEED));
        fill_table();
        wait (rst_n === 1'b1);

        // registers come out of reset cleared
        apb_read(ADDR_PRODUCT, rd, err);
        check_eq("reset_product", product_word(16'h0000, 1'b0), rd);
        check_eq("reset_pslverr", 32'd0, {31'b0, err});
        check_eq("reset_pready", 32'd1, {31'b0, last_pready});

        for (int k = 0; k < N_ROWS; k++) begin
            apb_write(ADDR_OPERAND, operand_word(tbl[k].a, tbl[k].b), err);
            check_eq({tbl[k].name, "_wr_err"}, {31'b0, tbl[k].err}, {31'b0, err});
            apb_read(ADDR_PRODUCT, rd, err);
            check_eq({tbl[k].name, "_product"}, product_word(tbl[k].prod, 1'b1), rd);
            check_eq({tbl[k].name, "_rd_err"}, {31'b0, tbl[k].err}, {31'b0, err});
            apb_read(ADDR_OPERAND, rd, err);
            check_eq({tbl[k].name, "_operand"}, operand_word(tbl[k].a, tbl[k].b), rd);
        end

        a_last = tbl[N_ROWS-1].a;
        b_last = tbl[N_ROWS-1].b;
        p_last = tbl[N_ROWS-1].prod;

        // error responses leave everything as it was
        apb_write(ADDR_PRODUCT, 32'h0001_dead, err);
        check_eq("wr_product_err", 32'd1, {31'b0, err});
        apb_read(ADDR_UNMAPPED, rd, err);
        check_eq("rd_unmapped_err", 32'd1, {31'b0, err});
        apb_write(ADDR_UNMAPPED, 32'h0000_5a5a, err);
        check_eq("wr_unmapped_err", 32'd1, {31'b0, err});
        apb_read(ADDR_PRODUCT, rd, err);
        check_eq("after_err_product", product_word(p_last, 1'b1), rd);
        check_eq("after_err_pslverr", 32'd0, {31'b0, err});
        apb_read(ADDR_OPERAND, rd, err);
        check_eq("after_err_operand", operand_word(a_last, b_last), rd);

        // two launches in flight, only the newer one shows
        a2 = 8'd19;
        b2 = 8'd251;
        apb_write(ADDR_OPERAND, operand_word(8'd200, 8'd3), err);
        check_eq("b2b_first_err", 32'd0, {31'b0, err});
        apb_write(ADDR_OPERAND, operand_word(a2, b2), err);
        check_eq("b2b_second_err", 32'd0, {31'b0, err});
        apb_read(ADDR_PRODUCT, rd, err);
        check_eq("b2b_product", product_word({8'b0, a2} * {8'b0, b2}, 1'b1), rd);

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== dv/tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter int PERIOD  = 20,
    parameter int RST_CYC = 8
) (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // released on a rising edge, like every other DUT input
    initial begin
        rst_n <= 1'b0;
        repeat (RST_CYC) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== hw/mul8_apb.sv ====
module mul8_apb (
    input  logic              clk,
    input  logic              rst_n,
    input  mul_pkg::apb_req_t apb_req,
    output mul_pkg::apb_rsp_t apb_rsp
);

    import mul_pkg::*;

    mul_req_t req;
    rows_t    rows;
    mul_rsp_t rsp;

    mul_apb_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .req     (req),
        .rsp     (rsp)
    );

    // partial products and reduction, rows registered
    dadda_reduce u_reduce (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rows  (rows)
    );

    final_add u_final (
        .clk   (clk),
        .rst_n (rst_n),
        .rows  (rows),
        .rsp   (rsp)
    );

endmodule

// ==== hw/mul_apb_regs.sv ====
module mul_apb_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  mul_pkg::apb_req_t apb_req,
    output mul_pkg::apb_rsp_t apb_rsp,
    output mul_pkg::mul_req_t req,
    input  mul_pkg::mul_rsp_t rsp
);

    import mul_pkg::*;

    logic              access;
    logic              hit_op;
    logic              hit_prod;
    logic              slverr;
    logic              launch;
    logic              done_now;
    logic              done_q;
    logic [APB_DW-1:0] rdata;
    mul_req_t          req_q;

    assign access   = apb_req.psel & apb_req.penable;
    assign hit_op   = apb_req.paddr == ADDR_OPERAND;
    assign hit_prod = apb_req.paddr == ADDR_PRODUCT;

    // unmapped address or write to the product register
    assign slverr = access & (~(hit_op | hit_prod) | (hit_prod & apb_req.pwrite));
    assign launch = access & apb_req.pwrite & hit_op;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= '0;
        end else begin
            req_q.valid <= launch;
            if (launch) begin
                req_q.a <= apb_req.pwdata[OP_W-1:0];
                req_q.b <= apb_req.pwdata[2*OP_W-1:OP_W];
            end
        end
    end

    assign req = req_q;

    // a finishing pair only counts when no newer pair is still in flight
    assign done_now = rsp.done & ~req_q.valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else begin
            if (launch) begin
                done_q <= 1'b0;
            end else if (done_now) begin
                done_q <= 1'b1;
            end
        end
    end

    always_comb begin
        rdata = '0;
        if (hit_op) begin
            rdata[2*OP_W-1:0] = {req_q.b, req_q.a};
        end else if (hit_prod) begin
            rdata[PROD_W-1:0] = rsp.product;
            rdata[DONE_BIT]   = done_q | done_now;  // covers the cycle before done_q sets
        end
    end

    assign apb_rsp = '{prdata: rdata, pready: 1'b1, pslverr: slverr};

    a_penable_psel : assert property (
        @(posedge clk) disable iff (!rst_n) apb_req.penable |-> apb_req.psel
    );

    a_launch_pulse : assert property (
        @(posedge clk) disable iff (!rst_n) req_q.valid |=> !req_q.valid
    );

endmodule

// ==== hw/final_add.sv ====
module final_add (
    input  logic              clk,
    input  logic              rst_n,
    input  mul_pkg::rows_t    rows,
    output mul_pkg::mul_rsp_t rsp
);

    import mul_pkg::*;

    logic [ROW_W-1:0]  sum;
    logic              cout;
    logic              done_q;
    logic [PROD_W-1:0] product_q;

    ks_adder #(.WIDTH(ROW_W)) u_ks (
        .a    (rows.row_x),
        .b    (rows.row_y),
        .sum  (sum),
        .cout (cout)
    );

    // product register reads back as zero before the first result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q    <= 1'b0;
            product_q <= '0;
        end else begin
            done_q <= rows.valid;  // one cycle pulse
            if (rows.valid) begin
                product_q <= {cout, sum, rows.lsb0};
            end
        end
    end

    assign rsp = '{done: done_q, product: product_q};

endmodule

// ==== hw/dadda_reduce.sv ====
module dadda_reduce (
    input  logic              clk,
    input  logic              rst_n,
    input  mul_pkg::mul_req_t req,
    output mul_pkg::rows_t    rows
);

    import mul_pkg::*;

    logic [OP_W-1:0][OP_W-1:0] pp;  // pp[i] sits at column offset i

    logic [7:0]  x1, y1, s1;
    logic [5:0]  x2, y2, s2;
    logic [3:0]  x3, y3, s3;
    logic [1:0]  x4, y4, s4;
    logic [11:0] x5, y5, s5;
    logic [9:0]  x6, y6, s6;
    logic        c1, c2, c3, c4, c5, c6;

    logic             valid_q;
    logic             lsb0_q;
    logic [ROW_W-1:0] row_x_q;
    logic [ROW_W-1:0] row_y_q;

    logic [PROD_W-1:0] rows_total;  // product rebuilt from the registered rows

    for (genvar i = 0; i < OP_W; i++) begin : g_pp
        assign pp[i] = req.a[i] ? req.b : '0;
    end

    // first stage, columns 4..11, 5..10, 6..9 and 7..8
    assign x1 = {pp[4][7], pp[3][7], pp[2][7], pp[1][7], pp[0][7:4]};
    assign y1 = {pp[5][6], pp[4][6], pp[3][6], pp[2][6], pp[1][6:3]};
    ks_adder #(.WIDTH(8)) u_ks1 (.a(x1), .b(y1), .sum(s1), .cout(c1));

    assign x2 = {pp[5][5], pp[4][5], pp[3][5], pp[2][5:3]};
    assign y2 = {pp[6][4], pp[5][4], pp[4][4], pp[3][4:2]};
    ks_adder #(.WIDTH(6)) u_ks2 (.a(x2), .b(y2), .sum(s2), .cout(c2));

    assign x3 = {pp[6][3], pp[5][3], pp[4][3:2]};
    assign y3 = {pp[7][2], pp[6][2], pp[5][2:1]};
    ks_adder #(.WIDTH(4)) u_ks3 (.a(x3), .b(y3), .sum(s3), .cout(c3));

    assign x4 = {1'b0, pp[6][1]};
    assign y4 = pp[7][1:0];
    ks_adder #(.WIDTH(2)) u_ks4 (.a(x4), .b(y4), .sum(s4), .cout(c4));

    // second stage, columns 2..13 and 3..12
    assign x5 = {pp[6][7], pp[7][5:3], s1[5:3], pp[6][0], pp[4][1], pp[2][2], pp[0][3:2]};
    assign y5 = {pp[7][6], pp[6][6:5], s1[6], s2[4:2], s1[2], pp[5][0], pp[3][1], pp[1][2:1]};
    ks_adder #(.WIDTH(12)) u_ks5 (.a(x5), .b(y5), .sum(s5), .cout(c5));

    assign x6 = {pp[5][7], s1[7], s2[5], s3[3:1], s2[1], s1[1], pp[4][0], pp[2][1]};
    assign y6 = {c1, c2, c3, c4, s4, s3[0], s2[0], s1[0], pp[3][0]};  // stage 1 carries
    ks_adder #(.WIDTH(10)) u_ks6 (.a(x6), .b(y6), .sum(s6), .cout(c6));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req.valid;
        end
    end

    // rows start at column 1
    always_ff @(posedge clk) begin
        if (req.valid) begin
            lsb0_q  <= pp[0][0];
            row_x_q <= {pp[7][7], s5[11:1], pp[2][0], pp[0][1]};
            row_y_q <= {c5, c6, s6, s5[0], pp[1][0]};
        end
    end

    assign rows = '{valid: valid_q, lsb0: lsb0_q, row_x: row_x_q, row_y: row_y_q};

    assign rows_total = {{1'b0, rows.row_x} + {1'b0, rows.row_y}, rows.lsb0};

    a_rows_follow : assert property (
        @(posedge clk) disable iff (!rst_n)
            req.valid |=> rows.valid && rows_total == $past(req.a) * $past(req.b)
    );

endmodule

// ==== hw/ks_adder.sv ====
module ks_adder #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    localparam int LVLS = $clog2(WIDTH);

    // group generate and propagate, one row per prefix level
    logic [LVLS:0][WIDTH-1:0] g;
    logic [LVLS:0][WIDTH-1:0] p;
    logic [WIDTH-1:0]         carry;

    assign g[0] = a & b;
    assign p[0] = a ^ b;

    for (genvar k = 0; k < LVLS; k++) begin : g_lvl
        localparam int D = 1 << k;  // span of this level

        for (genvar i = 0; i < WIDTH; i++) begin : g_bit
            if (i < D) begin : g_pass
                // group already reaches bit 0
                assign g[k+1][i] = g[k][i];
                assign p[k+1][i] = p[k][i];
            end else if (i < 2 * D) begin : g_gray
                // lower group ends at bit 0, only generate matters
                assign g[k+1][i] = g[k][i] | (p[k][i] & g[k][i-D]);
                assign p[k+1][i] = p[k][i];
            end else begin : g_black
                assign g[k+1][i] = g[k][i] | (p[k][i] & g[k][i-D]);
                assign p[k+1][i] = p[k][i] & p[k][i-D];
            end
        end
    end

    // no carry in
    if (WIDTH > 1) begin : g_carry
        assign carry = {g[LVLS][WIDTH-2:0], 1'b0};
    end else begin : g_carry0
        assign carry = 1'b0;
    end

    assign sum  = p[0] ^ carry;
    assign cout = g[LVLS][WIDTH-1];

endmodule

// ==== hw/mul_pkg.sv ====
package mul_pkg;

    // operand and product sizes
    localparam int OP_W   = 8;
    localparam int PROD_W = 2 * OP_W;
    localparam int ROW_W  = PROD_W - 2;  // final rows start at column 1, carry gives bit 15

    // apb bus
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    // register map, byte addresses
    localparam logic [APB_AW-1:0] ADDR_OPERAND = 8'h00;  // b in 15:8, a in 7:0
    localparam logic [APB_AW-1:0] ADDR_PRODUCT = 8'h04;  // read only
    localparam int                DONE_BIT     = PROD_W;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [APB_DW-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DW-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    // operand pair, valid for one cycle per launch
    typedef struct packed {
        logic            valid;
        logic [OP_W-1:0] a;
        logic [OP_W-1:0] b;
    } mul_req_t;

    // reduced rows between the two pipeline stages
    typedef struct packed {
        logic             valid;
        logic             lsb0;   // product bit 0
        logic [ROW_W-1:0] row_x;
        logic [ROW_W-1:0] row_y;
    } rows_t;

    typedef struct packed {
        logic              done;
        logic [PROD_W-1:0] product;
    } mul_rsp_t;

endpackage
